/* Makefile */
TOP       ?= tb_static_cnfg_slave
SIM_DIR   ?= sim_build
VERILATOR ?= verilator
LOG       ?= $(SIM_DIR)/sim.log

FLIST := static_cnfg_slave.f
SRCS  := $(shell grep -v '^+' $(FLIST)) rtl/cnfg_config.svh
BIN   := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(SIM_DIR)

run: $(BIN)
	$(BIN) > $(LOG)
	cat $(LOG)
	grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(SIM_DIR)

/* rtl/cnfg_bus_pkg.sv */
`include "cnfg_config.svh"

package cnfg_bus_pkg;

  // ------------------------------
  // Plain vectors
  typedef logic [`CNFG_ADDR_BITS-1:0]       axil_addr_t;
  typedef logic [$clog2(`CNFG_N_REGS)-1:0]  reg_idx_t;
  typedef logic [`CNFG_DATA_BITS-1:0]       reg_data_t;
  typedef logic [`CNFG_DATA_BITS/8-1:0]     reg_strb_t;

  // ------------------------------
  // Single-cycle register accesses from the bus port
  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    reg_data_t data;
    reg_strb_t strb;
  } reg_wr_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t idx;
  } reg_rd_t;

  // ------------------------------
  // Channel FSMs of the AXI4-Lite port
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACCEPT,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACCEPT,
    RD_DATA
  } rd_state_t;

endpackage

/* rtl/cnfg_config.svh */
`ifndef CNFG_CONFIG_SVH
`define CNFG_CONFIG_SVH

// Bus and register file geometry
`define CNFG_DATA_BITS     64
`define CNFG_N_REGS        32
// 5 index bits above 3 byte offset bits
`define CNFG_ADDR_BITS     8

`define CNFG_PROBE_ID      64'h5a3c_96e1_0f2d_b487
`define CNFG_PR_QDEPTH     8

// Register map, in 64-bit word slots
`define CNFG_PROBE_REG     0
`define CNFG_LOWSPEED_REG  8
`define CNFG_PR_CTRL_REG   10
`define CNFG_PR_STAT_REG   11
`define CNFG_PR_ADDR_REG   12
`define CNFG_PR_LEN_REG    13
`define CNFG_NET_IP_REG    20
`define CNFG_NET_MAC_REG   21
`define CNFG_NET_ARP_REG   22

// PR control bits
`define CNFG_PR_START      0
`define CNFG_PR_CTL        1
`define CNFG_PR_CLR        2

`endif

/* rtl/cnfg_regs.sv */
`timescale 1ns/10ps
`include "cnfg_config.svh"

module cnfg_regs (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  cnfg_bus_pkg::reg_wr_t   reg_wr,
  input  cnfg_bus_pkg::reg_rd_t   reg_rd,
  output cnfg_bus_pkg::reg_data_t rd_data,
  output logic                    pr_push,
  output shell_cmd_pkg::dma_req_t pr_req,
  input  logic                    pr_not_full,
  input  logic                    pr_done,
  output logic [2:0]              lowspeed_ctrl_0,
  output logic [2:0]              lowspeed_ctrl_1
);

  logic [5:0]              lowspeed_q;
  logic [2:0]              pr_ctrl_q;    // Start, ctl, clear
  logic                    done_q;
  shell_cmd_pkg::paddr_t   pr_addr_q;
  shell_cmd_pkg::dma_len_t pr_len_q;

  logic wr_lowspeed;
  logic wr_pr_ctrl;
  logic wr_pr_addr;
  logic wr_pr_len;
  cnfg_bus_pkg::reg_data_t lowspeed_nxt;
  cnfg_bus_pkg::reg_data_t addr_nxt;
  cnfg_bus_pkg::reg_data_t len_nxt;

  // Byte lanes with a strobe take the new data
  function automatic cnfg_bus_pkg::reg_data_t byte_merge(
    input cnfg_bus_pkg::reg_data_t old_word,
    input cnfg_bus_pkg::reg_data_t new_word,
    input cnfg_bus_pkg::reg_strb_t strb
  );
    cnfg_bus_pkg::reg_data_t res;
    res = old_word;
    for (int i = 0; i < `CNFG_DATA_BITS / 8; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // Write decode
  assign wr_lowspeed = reg_wr.valid && (reg_wr.idx == `CNFG_LOWSPEED_REG);
  assign wr_pr_ctrl  = reg_wr.valid && (reg_wr.idx == `CNFG_PR_CTRL_REG);
  assign wr_pr_addr  = reg_wr.valid && (reg_wr.idx == `CNFG_PR_ADDR_REG);
  assign wr_pr_len   = reg_wr.valid && (reg_wr.idx == `CNFG_PR_LEN_REG);

  assign lowspeed_nxt = byte_merge(cnfg_bus_pkg::reg_data_t'(lowspeed_q), reg_wr.data,
                                   reg_wr.strb);
  assign addr_nxt     = byte_merge(cnfg_bus_pkg::reg_data_t'(pr_addr_q), reg_wr.data,
                                   reg_wr.strb);
  assign len_nxt      = byte_merge(cnfg_bus_pkg::reg_data_t'(pr_len_q), reg_wr.data,
                                   reg_wr.strb);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lowspeed_q <= '1;
      pr_ctrl_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      pr_ctrl_q <= '0;  // Self-clearing after one cycle
      if (wr_lowspeed) begin
        lowspeed_q <= lowspeed_nxt[5:0];
      end
      if (wr_pr_ctrl && reg_wr.strb[0]) begin
        pr_ctrl_q <= reg_wr.data[2:0];
      end
      // Clear has priority over a done in the same cycle
      if (pr_ctrl_q[`CNFG_PR_CLR]) begin
        done_q <= 1'b0;
      end else if (pr_done) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_pr_addr) begin
      pr_addr_q <= addr_nxt[47:0];
    end
    if (wr_pr_len) begin
      pr_len_q <= len_nxt[27:0];
    end
  end

  // ------------------------------
  // Outputs
  assign lowspeed_ctrl_0 = lowspeed_q[2:0];
  assign lowspeed_ctrl_1 = lowspeed_q[5:3];

  assign pr_push = pr_ctrl_q[`CNFG_PR_START];
  always_comb begin
    pr_req.ctl   = pr_ctrl_q[`CNFG_PR_CTL];
    pr_req.paddr = pr_addr_q;
    pr_req.len   = pr_len_q;
  end

  // ------------------------------
  // Read mux, registered on the read handshake
  always_ff @(posedge aclk) begin
    if (reg_rd.valid) begin
      case (reg_rd.idx)
        `CNFG_PROBE_REG:    rd_data <= `CNFG_PROBE_ID;
        `CNFG_LOWSPEED_REG: rd_data <= cnfg_bus_pkg::reg_data_t'(lowspeed_q);
        `CNFG_PR_STAT_REG:  rd_data <= cnfg_bus_pkg::reg_data_t'({pr_not_full, done_q});
        `CNFG_PR_ADDR_REG:  rd_data <= cnfg_bus_pkg::reg_data_t'(pr_addr_q);
        `CNFG_PR_LEN_REG:   rd_data <= cnfg_bus_pkg::reg_data_t'(pr_len_q);
        default:            rd_data <= '0;  // Network regs are write only
      endcase
    end
  end

endmodule

/* rtl/ctrl_axil_port.sv */
`timescale 1ns/10ps
`include "cnfg_config.svh"

module ctrl_axil_port (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  cnfg_bus_pkg::axil_addr_t awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  cnfg_bus_pkg::reg_data_t  wdata,
  input  cnfg_bus_pkg::reg_strb_t  wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic                     bvalid,
  output logic [1:0]               bresp,
  input  logic                     bready,
  input  cnfg_bus_pkg::axil_addr_t araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic                     rvalid,
  output cnfg_bus_pkg::reg_data_t  rdata,
  output logic [1:0]               rresp,
  input  logic                     rready,
  output cnfg_bus_pkg::reg_wr_t    reg_wr,
  output cnfg_bus_pkg::reg_rd_t    reg_rd,
  input  cnfg_bus_pkg::reg_data_t  rd_data
);

  localparam int OFFS_BITS = $clog2(`CNFG_DATA_BITS / 8);

  cnfg_bus_pkg::wr_state_t wr_state;
  cnfg_bus_pkg::rd_state_t rd_state;
  logic wr_hs;
  logic rd_hs;

  // ------------------------------
  // Write channel
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_state <= cnfg_bus_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        cnfg_bus_pkg::WR_IDLE: begin
          if (awvalid && wvalid) begin  // Need both address and data
            wr_state <= cnfg_bus_pkg::WR_ACCEPT;
          end
        end
        cnfg_bus_pkg::WR_ACCEPT: begin
          wr_state <= wr_hs ? cnfg_bus_pkg::WR_RESP : cnfg_bus_pkg::WR_IDLE;
        end
        cnfg_bus_pkg::WR_RESP: begin
          if (bready) begin
            wr_state <= cnfg_bus_pkg::WR_IDLE;
          end
        end
        default: wr_state <= cnfg_bus_pkg::WR_IDLE;
      endcase
    end
  end

  assign awready = (wr_state == cnfg_bus_pkg::WR_ACCEPT);
  assign wready  = (wr_state == cnfg_bus_pkg::WR_ACCEPT);
  assign bvalid  = (wr_state == cnfg_bus_pkg::WR_RESP);
  assign bresp   = 2'b00;  // OKAY
  assign wr_hs   = awready && awvalid && wready && wvalid;

  always_comb begin
    reg_wr.valid = wr_hs;
    reg_wr.idx   = awaddr[`CNFG_ADDR_BITS-1:OFFS_BITS];  // Drop byte offset
    reg_wr.data  = wdata;
    reg_wr.strb  = wstrb;
  end

  // ------------------------------
  // Read channel
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_state <= cnfg_bus_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        cnfg_bus_pkg::RD_IDLE: begin
          if (arvalid) begin
            rd_state <= cnfg_bus_pkg::RD_ACCEPT;
          end
        end
        cnfg_bus_pkg::RD_ACCEPT: begin
          rd_state <= rd_hs ? cnfg_bus_pkg::RD_DATA : cnfg_bus_pkg::RD_IDLE;
        end
        cnfg_bus_pkg::RD_DATA: begin
          if (rready) begin
            rd_state <= cnfg_bus_pkg::RD_IDLE;
          end
        end
        default: rd_state <= cnfg_bus_pkg::RD_IDLE;
      endcase
    end
  end

  assign arready = (rd_state == cnfg_bus_pkg::RD_ACCEPT);
  assign rvalid  = (rd_state == cnfg_bus_pkg::RD_DATA);
  assign rresp   = 2'b00;
  assign rd_hs   = arready && arvalid;

  // Read data is registered in the register block on the handshake edge
  assign rdata = rd_data;

  always_comb begin
    reg_rd.valid = rd_hs;
    reg_rd.idx   = araddr[`CNFG_ADDR_BITS-1:OFFS_BITS];
  end

endmodule

/* rtl/net_cmd_out.sv */
`timescale 1ns/10ps
`include "cnfg_config.svh"

module net_cmd_out (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  cnfg_bus_pkg::reg_wr_t     reg_wr,
  output logic                      set_ip_valid,
  output shell_cmd_pkg::ip_addr_t   set_ip_addr,
  output logic                      set_mac_valid,
  output shell_cmd_pkg::mac_addr_t  set_mac_addr,
  output logic                      arp_req_valid,
  output shell_cmd_pkg::ip_addr_t   arp_req_addr,
  input  logic                      arp_req_ready
);

  logic ip_hit;
  logic mac_hit;
  logic arp_hit;

  // Whole word taken, strobes not looked at
  assign ip_hit  = reg_wr.valid && (reg_wr.idx == `CNFG_NET_IP_REG);
  assign mac_hit = reg_wr.valid && (reg_wr.idx == `CNFG_NET_MAC_REG);
  assign arp_hit = reg_wr.valid && (reg_wr.idx == `CNFG_NET_ARP_REG);

  // ------------------------------
  // Command valids
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      set_ip_valid  <= 1'b0;
      set_mac_valid <= 1'b0;
      arp_req_valid <= 1'b0;
    end else begin
      set_ip_valid  <= ip_hit;   // Single-cycle pulse
      set_mac_valid <= mac_hit;
      if (arp_hit) begin
        arp_req_valid <= 1'b1;  // New lookup overrides a pending one
      end else if (arp_req_ready) begin
        arp_req_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ip_hit) begin
      set_ip_addr <= reg_wr.data[31:0];
    end
    if (mac_hit) begin
      set_mac_addr <= reg_wr.data[47:0];
    end
    if (arp_hit) begin
      arp_req_addr <= {<<8{reg_wr.data[31:0]}};  // Byte-reversed target
    end
  end

endmodule

/* rtl/pr_dma_queue.sv */
`timescale 1ns/10ps
`include "cnfg_config.svh"

module pr_dma_queue #(
  parameter int DEPTH = `CNFG_PR_QDEPTH
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    push,
  input  shell_cmd_pkg::dma_req_t push_req,
  output logic                    not_full,
  output logic                    m_valid,
  output shell_cmd_pkg::dma_req_t m_req,
  input  logic                    m_ready
);

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  shell_cmd_pkg::dma_req_t mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic do_push;
  logic do_pop;

  assign not_full = (count != CNT_BITS'(DEPTH));
  assign m_valid  = (count != '0);
  assign m_req    = mem[rd_ptr];  // Head of queue
  assign do_push  = push && not_full;  // Full drops the start
  assign do_pop   = m_valid && m_ready;

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_req;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
    end
  end

endmodule

/* rtl/shell_cmd_pkg.sv */
package shell_cmd_pkg;

  // ------------------------------
  // DMA request toward the engine
  typedef logic [47:0] paddr_t;    // Host physical address
  typedef logic [27:0] dma_len_t;  // Bytes

  typedef struct packed {
    logic     ctl;
    paddr_t   paddr;
    dma_len_t len;
  } dma_req_t;

  // ------------------------------
  // Network port configuration
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;

endpackage

/* rtl/static_cnfg_slave.sv */
`timescale 1ns/10ps

module static_cnfg_slave (
  input  logic                      aclk,
  input  logic                      aresetn,
  // AXI4-Lite host port
  input  cnfg_bus_pkg::axil_addr_t  awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  cnfg_bus_pkg::reg_data_t   wdata,
  input  cnfg_bus_pkg::reg_strb_t   wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic                      bvalid,
  output logic [1:0]                bresp,
  input  logic                      bready,
  input  cnfg_bus_pkg::axil_addr_t  araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic                      rvalid,
  output cnfg_bus_pkg::reg_data_t   rdata,
  output logic [1:0]                rresp,
  input  logic                      rready,
  // Low-speed control
  output logic [2:0]                lowspeed_ctrl_0,
  output logic [2:0]                lowspeed_ctrl_1,
  // PR DMA requests
  output logic                      m_pr_dma_valid,
  output shell_cmd_pkg::dma_req_t   m_pr_dma_req,
  input  logic                      m_pr_dma_ready,
  input  logic                      pr_done,
  // Network port commands
  output logic                      set_ip_valid,
  output shell_cmd_pkg::ip_addr_t   set_ip_addr,
  output logic                      set_mac_valid,
  output shell_cmd_pkg::mac_addr_t  set_mac_addr,
  output logic                      arp_req_valid,
  output shell_cmd_pkg::ip_addr_t   arp_req_addr,
  input  logic                      arp_req_ready
);

  cnfg_bus_pkg::reg_wr_t   reg_wr;
  cnfg_bus_pkg::reg_rd_t   reg_rd;
  cnfg_bus_pkg::reg_data_t rd_data;
  logic                    pr_push;
  shell_cmd_pkg::dma_req_t pr_req;
  logic                    pr_not_full;

  // ------------------------------
  ctrl_axil_port u_port (
    .aclk, .aresetn,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bvalid, .bresp, .bready,
    .araddr, .arvalid, .arready,
    .rvalid, .rdata, .rresp, .rready,
    .reg_wr, .reg_rd, .rd_data
  );

  cnfg_regs u_regs (
    .aclk, .aresetn,
    .reg_wr, .reg_rd, .rd_data,
    .pr_push, .pr_req, .pr_not_full, .pr_done,
    .lowspeed_ctrl_0, .lowspeed_ctrl_1
  );

  // PR requests wait here for the DMA engine
  pr_dma_queue u_pr_queue (
    .aclk, .aresetn,
    .push     (pr_push),
    .push_req (pr_req),
    .not_full (pr_not_full),
    .m_valid  (m_pr_dma_valid),
    .m_req    (m_pr_dma_req),
    .m_ready  (m_pr_dma_ready)
  );

  net_cmd_out u_net (
    .aclk, .aresetn,
    .reg_wr,
    .set_ip_valid, .set_ip_addr,
    .set_mac_valid, .set_mac_addr,
    .arp_req_valid, .arp_req_addr, .arp_req_ready
  );

endmodule

/* static_cnfg_slave.f */
+incdir+rtl
rtl/cnfg_bus_pkg.sv
rtl/shell_cmd_pkg.sv
rtl/ctrl_axil_port.sv
rtl/cnfg_regs.sv
rtl/pr_dma_queue.sv
rtl/net_cmd_out.sv
rtl/static_cnfg_slave.sv
verification/tb_static_cnfg_slave.sv

/* verification/tb_static_cnfg_slave.sv */
`timescale 1ns/10ps
`include "cnfg_config.svh"

module tb_static_cnfg_slave;

  typedef logic [79:0] chk_t;  // Wide enough for a DMA request

  // About 350 cycles of tests plus a wide margin for back-pressure
  localparam int MAX_CYCLES = 4000;

  localparam logic [1:0] READY_HIGH   = 2'd0;
  localparam logic [1:0] READY_LOW    = 2'd1;
  localparam logic [1:0] READY_RANDOM = 2'd2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  localparam cnfg_bus_pkg::reg_idx_t PROBE_IDX = `CNFG_PROBE_REG;
  localparam cnfg_bus_pkg::reg_idx_t LS_IDX    = `CNFG_LOWSPEED_REG;
  localparam cnfg_bus_pkg::reg_idx_t CTRL_IDX  = `CNFG_PR_CTRL_REG;
  localparam cnfg_bus_pkg::reg_idx_t STAT_IDX  = `CNFG_PR_STAT_REG;
  localparam cnfg_bus_pkg::reg_idx_t ADDR_IDX  = `CNFG_PR_ADDR_REG;
  localparam cnfg_bus_pkg::reg_idx_t LEN_IDX   = `CNFG_PR_LEN_REG;
  localparam cnfg_bus_pkg::reg_idx_t IP_IDX    = `CNFG_NET_IP_REG;
  localparam cnfg_bus_pkg::reg_idx_t MAC_IDX   = `CNFG_NET_MAC_REG;
  localparam cnfg_bus_pkg::reg_idx_t ARP_IDX   = `CNFG_NET_ARP_REG;

  logic aclk = 1'b0;
  logic aresetn;
  cnfg_bus_pkg::axil_addr_t awaddr;
  cnfg_bus_pkg::axil_addr_t araddr;
  cnfg_bus_pkg::reg_data_t  wdata;
  cnfg_bus_pkg::reg_data_t  rdata;
  cnfg_bus_pkg::reg_strb_t  wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp;
  logic [1:0] rresp;
  logic [2:0] lowspeed_ctrl_0;
  logic [2:0] lowspeed_ctrl_1;
  logic m_pr_dma_valid;
  logic m_pr_dma_ready = 1'b1;
  shell_cmd_pkg::dma_req_t m_pr_dma_req;
  logic pr_done;
  logic set_ip_valid, set_mac_valid, arp_req_valid, arp_req_ready;
  shell_cmd_pkg::ip_addr_t  set_ip_addr;
  shell_cmd_pkg::ip_addr_t  arp_req_addr;
  shell_cmd_pkg::mac_addr_t set_mac_addr;

  // Reference model state
  cnfg_bus_pkg::reg_data_t model_regs [`CNFG_N_REGS];
  logic model_done;
  logic [1:0] ready_mode;
  shell_cmd_pkg::dma_req_t exp_dma[$];

  // Observed transfers, filled by the monitor
  shell_cmd_pkg::dma_req_t  dma_seen[$];
  shell_cmd_pkg::ip_addr_t  ip_seen[$];
  shell_cmd_pkg::mac_addr_t mac_seen[$];
  shell_cmd_pkg::ip_addr_t  arp_seen[$];

  // Pending checks for the compare process
  string chk_name[$];
  chk_t  chk_exp[$];
  chk_t  chk_act[$];
  int    chk_done = 0;
  int    errors = 0;
  int    cycles = 0;

  static_cnfg_slave UUT (.*);

  always #2 aclk = ~aclk;

  // ------------------------------
  // Reference model
  function automatic cnfg_bus_pkg::reg_data_t apply_strobes(
    input cnfg_bus_pkg::reg_data_t old_word,
    input cnfg_bus_pkg::reg_data_t new_word,
    input cnfg_bus_pkg::reg_strb_t strb
  );
    cnfg_bus_pkg::reg_data_t res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic queue_not_full();
    return (exp_dma.size() - dma_seen.size()) < `CNFG_PR_QDEPTH;
  endfunction

  function automatic cnfg_bus_pkg::reg_data_t ctrl_word(input logic start, input logic ctl,
                                                        input logic clr);
    cnfg_bus_pkg::reg_data_t w;
    w = '0;
    w[`CNFG_PR_START] = start;
    w[`CNFG_PR_CTL]   = ctl;
    w[`CNFG_PR_CLR]   = clr;
    return w;
  endfunction

  function automatic void model_write(input cnfg_bus_pkg::reg_idx_t idx,
                                      input cnfg_bus_pkg::reg_data_t data,
                                      input cnfg_bus_pkg::reg_strb_t strb);
    cnfg_bus_pkg::reg_data_t merged;
    shell_cmd_pkg::dma_req_t req;
    merged = apply_strobes(model_regs[idx], data, strb);
    case (idx)
      LS_IDX:   model_regs[idx] = merged & 64'h3f;
      ADDR_IDX: model_regs[idx] = merged & 64'hffff_ffff_ffff;
      LEN_IDX:  model_regs[idx] = merged & 64'h0fff_ffff;
      CTRL_IDX: begin
        if (strb[0] && data[`CNFG_PR_START] && queue_not_full()) begin
          req.ctl   = data[`CNFG_PR_CTL];
          req.paddr = model_regs[ADDR_IDX][47:0];
          req.len   = model_regs[LEN_IDX][27:0];
          exp_dma.push_back(req);
        end
        if (strb[0] && data[`CNFG_PR_CLR]) begin
          model_done = 1'b0;
        end
      end
      default: ;
    endcase
  endfunction

  function automatic cnfg_bus_pkg::reg_data_t expected_read(input cnfg_bus_pkg::reg_idx_t idx);
    case (idx)
      PROBE_IDX:                 return `CNFG_PROBE_ID;
      LS_IDX, ADDR_IDX, LEN_IDX: return model_regs[idx];
      STAT_IDX:                  return {62'd0, queue_not_full(), model_done};
      default:                   return '0;  // Includes write-only network regs
    endcase
  endfunction

  function automatic void post_check(input string name, input chk_t exp, input chk_t act);
    chk_name.push_back(name);
    chk_exp.push_back(exp);
    chk_act.push_back(act);
  endfunction

  // ------------------------------
  // AXI4-Lite host tasks
  task automatic axil_write(input cnfg_bus_pkg::reg_idx_t idx,
                            input cnfg_bus_pkg::reg_data_t data,
                            input cnfg_bus_pkg::reg_strb_t strb);
    model_write(idx, data, strb);
    awaddr  = {idx, 3'b000};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge aclk);
    while (!awready) @(negedge aclk);
    @(negedge aclk);  // Handshake edge has passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    while (!bvalid) @(negedge aclk);
    post_check($sformatf("write reg %0d bresp", idx), chk_t'(RESP_OKAY), chk_t'(bresp));
    @(negedge aclk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input cnfg_bus_pkg::reg_idx_t idx, input string name);
    cnfg_bus_pkg::reg_data_t exp;
    exp     = expected_read(idx);
    araddr  = {idx, 3'b000};
    arvalid = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) @(negedge aclk);
    post_check(name, chk_t'(exp), chk_t'(rdata));
    post_check({name, " rresp"}, chk_t'(RESP_OKAY), chk_t'(rresp));
    @(negedge aclk);
    rready = 1'b0;
  endtask

  task automatic check_lowspeed_outputs(input string name);
    post_check({name, " out0"}, chk_t'(model_regs[LS_IDX][2:0]), chk_t'(lowspeed_ctrl_0));
    post_check({name, " out1"}, chk_t'(model_regs[LS_IDX][5:3]), chk_t'(lowspeed_ctrl_1));
  endtask

  // ------------------------------
  // DMA engine ready, the only driver of m_pr_dma_ready
  always @(negedge aclk) begin
    case (ready_mode)
      READY_LOW:    m_pr_dma_ready = 1'b0;
      READY_RANDOM: m_pr_dma_ready = 1'($urandom % 2);
      default:      m_pr_dma_ready = 1'b1;
    endcase
  end

  // Values before the edge, so transfers of this edge
  always @(posedge aclk) begin
    if (aresetn) begin
      if (m_pr_dma_valid && m_pr_dma_ready) begin
        dma_seen.push_back(m_pr_dma_req);
      end
      if (set_ip_valid) begin
        ip_seen.push_back(set_ip_addr);
      end
      if (set_mac_valid) begin
        mac_seen.push_back(set_mac_addr);
      end
      if (arp_req_valid && arp_req_ready) begin
        arp_seen.push_back(arp_req_addr);
      end
    end
  end

  always @(posedge aclk) begin : compare_proc
    while (chk_done < chk_name.size()) begin
      if (chk_act[chk_done] !== chk_exp[chk_done]) begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", chk_name[chk_done],
                 chk_exp[chk_done], chk_act[chk_done]);
      end
      chk_done++;
    end
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles, %0d errors so far", cycles, errors);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------
  initial begin : main
    cnfg_bus_pkg::reg_idx_t  idx;
    cnfg_bus_pkg::reg_data_t data;
    int hold;
    void'($urandom(32'hf295da34));
    aresetn = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    pr_done = 1'b0;
    arp_req_ready = 1'b0;
    ready_mode = READY_HIGH;
    model_done = 1'b0;
    for (int i = 0; i < `CNFG_N_REGS; i++) begin
      model_regs[i] = '0;
    end
    model_regs[LS_IDX] = 64'h3f;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);

    // Reset values
    axil_read(PROBE_IDX, "reset probe");
    axil_read(LS_IDX, "reset lowspeed");
    axil_read(STAT_IDX, "reset pr status");
    check_lowspeed_outputs("reset lowspeed");

    // Random strobed writes, full writes first so no byte is unknown
    axil_write(ADDR_IDX, {$urandom, $urandom}, 8'hff);
    axil_write(LEN_IDX, {$urandom, $urandom}, 8'hff);
    for (int i = 0; i < 20; i++) begin
      case ($urandom % 3)
        0:       idx = LS_IDX;
        1:       idx = ADDR_IDX;
        default: idx = LEN_IDX;
      endcase
      axil_write(idx, {$urandom, $urandom}, cnfg_bus_pkg::reg_strb_t'($urandom));
      axil_read(idx, $sformatf("random write %0d", i));
      check_lowspeed_outputs($sformatf("random write %0d", i));
    end

    // PR starts under back-pressure
    ready_mode = READY_RANDOM;
    for (int i = 0; i < 3; i++) begin
      axil_write(ADDR_IDX, {$urandom, $urandom}, 8'hff);
      axil_write(LEN_IDX, {$urandom, $urandom}, 8'hff);
      axil_write(CTRL_IDX, ctrl_word(1'b1, i == 1, 1'b0), 8'hff);
    end
    while (dma_seen.size() < 3) @(negedge aclk);

    // Sticky done flag
    ready_mode = READY_HIGH;
    pr_done    = 1'b1;
    model_done = 1'b1;
    @(negedge aclk);
    pr_done = 1'b0;
    axil_read(STAT_IDX, "done set");
    axil_write(CTRL_IDX, ctrl_word(1'b0, 1'b0, 1'b1), 8'hff);
    axil_read(STAT_IDX, "done cleared");

    // Fill the queue, then one start too many
    ready_mode = READY_LOW;
    repeat (2) @(negedge aclk);
    axil_write(LEN_IDX, 64'h0000_0000_0123_4000, 8'hff);
    for (int i = 0; i < `CNFG_PR_QDEPTH + 1; i++) begin
      if (i == `CNFG_PR_QDEPTH) begin
        axil_read(STAT_IDX, "queue full");
      end
      axil_write(ADDR_IDX, 64'h0000_7f00_0000_1000 + 64'(i) * 64'h1000, 8'hff);
      axil_write(CTRL_IDX, ctrl_word(1'b1, 1'(i % 2), 1'b0), 8'hff);
    end
    axil_read(STAT_IDX, "queue full after drop");
    ready_mode = READY_HIGH;
    while (dma_seen.size() < exp_dma.size()) @(negedge aclk);
    repeat (10) @(negedge aclk);
    post_check("pr dma count", chk_t'(exp_dma.size()), chk_t'(dma_seen.size()));
    for (int i = 0; i < exp_dma.size(); i++) begin
      post_check($sformatf("pr dma %0d", i), chk_t'(exp_dma[i]), chk_t'(dma_seen[i]));
    end

    // Network commands
    data = {$urandom, $urandom};
    axil_write(IP_IDX, data, 8'hf0);  // Low bytes unstrobed but still taken
    while (ip_seen.size() == 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
    post_check("set ip count", chk_t'(1), chk_t'(ip_seen.size()));
    post_check("set ip addr", chk_t'(data[31:0]), chk_t'(ip_seen[0]));

    data = {$urandom, $urandom};
    axil_write(MAC_IDX, data, 8'hff);
    while (mac_seen.size() == 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
    post_check("set mac count", chk_t'(1), chk_t'(mac_seen.size()));
    post_check("set mac addr", chk_t'(data[47:0]), chk_t'(mac_seen[0]));

    data = {$urandom, $urandom};
    hold = int'($urandom % 8) + 3;
    axil_write(ARP_IDX, data, 8'hff);
    repeat (hold) @(negedge aclk);
    arp_req_ready = 1'b1;
    while (arp_seen.size() == 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
    arp_req_ready = 1'b0;
    post_check("arp count", chk_t'(1), chk_t'(arp_seen.size()));
    post_check("arp addr", chk_t'({data[7:0], data[15:8], data[23:16], data[31:24]}),
               chk_t'(arp_seen[0]));
    axil_read(IP_IDX, "ip reg read");
    axil_read(MAC_IDX, "mac reg read");
    axil_read(ARP_IDX, "arp reg read");

    while (chk_done < chk_name.size()) @(negedge aclk);
    $display("Checks: %0d run, %0d errors", chk_name.size(), errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
